/* design/norm_pkg.sv */
// Shared definitions for the divide/sqrt normalize-and-round back end.
// Holds the FP32/FP16 field widths, the datapath vector types, the format
// and rounding-mode encodings, and the flag bit positions.
// Modules import it inside their body and use scoped names on their ports.

package norm_pkg;

  //////////////////////////////////////////////////
  // Format field widths
  //////////////////////////////////////////////////
  localparam int c_mant_fp32 = 23;  // FP32 fraction bits
  localparam int c_exp_fp32  = 8;   // FP32 exponent bits
  localparam int c_mant_fp16 = 10;  // FP16 fraction bits
  localparam int c_exp_fp16  = 5;   // FP16 exponent bits

  //////////////////////////////////////////////////
  // Datapath types
  //////////////////////////////////////////////////
  // Hidden bit, 23 fraction bits, 4 guard bits
  typedef logic [c_mant_fp32+4:0] mant_in_t;
  typedef logic [c_mant_fp32:0] mant_t;            // Normalized, hidden bit on top
  typedef logic [c_mant_fp32+4:0] mant_ext_t;      // Bits below mant_t, for rounding
  // Biased exponent plus overflow bit and sign bit
  typedef logic signed [c_exp_fp32+1:0] exp_in_t;
  typedef logic [c_exp_fp32-1:0] exp_t;            // Biased result exponent
  typedef logic [31:0] result_t;                   // Packed result, FP16 boxed
  typedef logic [4:0] fflags_t;                    // {NV, DZ, OF, UF, NX}

  // Exponent 1, where a clear top bit already means denormal
  localparam exp_in_t c_exp_one = 10'sd1;

  // All-ones exponent per format, Inf/NaN encoding
  localparam exp_t c_exp_max_fp32 = '1;
  localparam exp_t c_exp_max_fp16 = exp_t'((1 << c_exp_fp16) - 1);

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////
  typedef enum logic {
    fmt_fp32 = 1'b0,
    fmt_fp16 = 1'b1   // Result NaN-boxed into 32 bits
  } fp_fmt_e;

  typedef enum logic [1:0] {
    rm_nearest   = 2'h0,  // Ties to even
    rm_trunc     = 2'h1,  // Toward zero
    rm_plus_inf  = 2'h2,
    rm_minus_inf = 2'h3
  } round_mode_e;

  // Quiet NaN fraction, top fraction bit only
  // FP16 takes the top 10 bits of this, so the same pattern serves both
  localparam logic [c_mant_fp32-1:0] c_mant_nan = {1'b1, {(c_mant_fp32-1){1'b0}}};

  //////////////////////////////////////////////////
  // Flag positions in fflags_t
  //////////////////////////////////////////////////
  localparam int c_flag_nv = 4;  // Invalid
  localparam int c_flag_dz = 3;  // Divide by zero
  localparam int c_flag_of = 2;  // Overflow
  localparam int c_flag_uf = 1;  // Underflow
  localparam int c_flag_nx = 0;  // Inexact

endpackage

/* design/special_case_check.sv */
// Special-operand classifier for the divide/sqrt back end.
// Looks at the operand flags and the operation and decides whether the
// result is fixed (NaN, Inf or zero) regardless of the mantissa path.
// Purely combinational; mant_normalizer registers its outputs.

`timescale 1ns/100ps

module special_case_check (
  input  logic              div_en,
  input  logic              sqrt_en,
  input  logic              sign_in,
  input  logic              inf_a,
  input  logic              inf_b,
  input  logic              zero_a,
  input  logic              zero_b,
  input  logic              nan_a,
  input  logic              nan_b,
  input  logic              snan,
  output logic              special_hit,       // Some special case applies
  output logic              special_exp_max,   // Exponent all ones, else zero
  output logic              special_mant_nan,  // Quiet NaN fraction, else zero
  output logic              special_sign,
  output norm_pkg::fflags_t special_flags
);
  import norm_pkg::*;

  // Priority chain, first match wins
  always_comb
  begin
    special_hit      = 1'b1;
    special_exp_max  = 1'b0;
    special_mant_nan = 1'b0;
    special_sign     = sign_in;
    special_flags    = '0;
    if (nan_a || nan_b)
    begin
      special_exp_max          = 1'b1;  // Canonical NaN
      special_mant_nan         = 1'b1;
      special_sign             = 1'b0;
      special_flags[c_flag_nv] = snan;  // Only signalling NaN is invalid
    end
    else if (inf_a && div_en && inf_b)
    begin
      special_exp_max          = 1'b1;  // Inf/Inf
      special_mant_nan         = 1'b1;
      special_sign             = 1'b0;
      special_flags[c_flag_nv] = 1'b1;
    end
    else if (inf_a)
      special_exp_max = 1'b1;           // Signed Inf, exact
    else if (div_en && inf_b)
      special_exp_max = 1'b0;           // x/Inf, signed zero
    else if (zero_a && div_en && zero_b)
    begin
      special_exp_max          = 1'b1;  // 0/0
      special_mant_nan         = 1'b1;
      special_sign             = 1'b0;
      special_flags[c_flag_nv] = 1'b1;
    end
    else if (zero_a)
      special_exp_max = 1'b0;           // Signed zero
    else if (div_en && zero_b)
    begin
      special_exp_max          = 1'b1;  // x/0, signed Inf
      special_flags[c_flag_dz] = 1'b1;
    end
    else if (sqrt_en && sign_in)
    begin
      special_exp_max          = 1'b1;  // sqrt of negative
      special_mant_nan         = 1'b1;
      special_sign             = 1'b0;
      special_flags[c_flag_nv] = 1'b1;
    end
    else
      special_hit = 1'b0;               // Ordinary operand, mantissa path
  end

  // Upstream issues one operation at a time
  always_comb
  begin
    a_op_exclusive: assert (!(div_en && sqrt_en))
      else $error("div_en and sqrt_en high together");
  end

endmodule

/* design/mant_normalizer.sv */
// Stage 1 of the normalize-and-round pipeline.
// Normalizes the incoming quotient/root, moves tiny results into the
// denormal range, detects exponent overflow, or substitutes the special
// result from special_case_check. Everything is registered on in_valid,
// one cycle of latency; round_unit consumes the *_s1 outputs.

`timescale 1ns/100ps

module mant_normalizer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  norm_pkg::mant_in_t    mant_in,
  input  norm_pkg::exp_in_t     exp_in,
  input  logic                  sign_in,
  input  norm_pkg::fp_fmt_e     fmt,
  input  norm_pkg::round_mode_e rm,
  input  logic                  special_hit,
  input  logic                  special_exp_max,
  input  logic                  special_mant_nan,
  input  logic                  special_sign,
  input  norm_pkg::fflags_t     special_flags,
  output logic                  valid_s1,
  output norm_pkg::mant_t       mant_norm,
  output norm_pkg::mant_ext_t   mant_ext,
  output norm_pkg::exp_t        exp_norm,
  output logic                  sign_s1,
  output norm_pkg::fflags_t     flags_s1,
  output norm_pkg::fp_fmt_e     fmt_s1,
  output norm_pkg::round_mode_e rm_s1,
  output logic                  force_exact   // Result must not be rounded
);
  import norm_pkg::*;

  localparam int c_top = $bits(mant_in_t) - 1;  // Hidden bit position
  // Largest right shift that still leaves a round bit
  localparam logic signed [10:0] c_rs_lim_fp32 = 11'(c_mant_fp32 + 1);
  localparam logic signed [10:0] c_rs_lim_fp16 = 11'(c_mant_fp16 + 1);

  logic signed [10:0] rs_amt;  // 1 - exp, positive when exp <= 0
  logic [$bits(mant_t)+$bits(mant_ext_t)-1:0] rs_vec;
  logic      rs_too_far;
  exp_t      exp_max;          // All-ones exponent of fmt
  exp_in_t   exp_max_in;
  exp_in_t   exp_dec;          // Exponent after left shift

  mant_t     mant_d;
  mant_ext_t ext_d;
  exp_t      exp_d;
  logic      sign_d;
  fflags_t   flags_d;
  logic      exact_d;

  //////////////////////////////////////////////////
  // Shift amounts and limits
  //////////////////////////////////////////////////
  assign rs_amt  = 11'sd1 - $signed({exp_in[9], exp_in});
  assign rs_vec  = {mant_in, {$bits(mant_t){1'b0}}} >> rs_amt[5:0];  // Low bits stay sticky
  assign exp_dec = exp_in - 10'sd1;

  always_comb
  begin
    if (fmt == fmt_fp32)
    begin
      exp_max    = c_exp_max_fp32;
      rs_too_far = rs_amt > c_rs_lim_fp32;
    end
    else
    begin
      exp_max    = c_exp_max_fp16;
      rs_too_far = rs_amt > c_rs_lim_fp16;
    end
  end

  assign exp_max_in = {2'b00, exp_max};

  //////////////////////////////////////////////////
  // Case selection
  //////////////////////////////////////////////////
  always_comb
  begin
    mant_d  = '0;
    ext_d   = '0;
    exp_d   = '0;
    sign_d  = sign_in;
    flags_d = '0;
    exact_d = 1'b0;
    if (special_hit)
    begin
      mant_d  = special_mant_nan ? {1'b0, c_mant_nan} : '0;
      exp_d   = special_exp_max ? exp_max : '0;
      sign_d  = special_sign;
      flags_d = special_flags;
      exact_d = 1'b1;
    end
    else if (exp_in == '0 && mant_in == '0)
      exact_d = 1'b1;                        // True zero
    else if (rs_amt > 11'sd0)                // Exp zero or negative
    begin
      flags_d[c_flag_uf] = 1'b1;
      if (rs_too_far)
      begin
        flags_d[c_flag_nx] = 1'b1;           // Flushed to signed zero
        exact_d            = 1'b1;
      end
      else
        {mant_d, ext_d} = rs_vec;            // Denormal, exp field 0
    end
    else if (exp_in == c_exp_one && !mant_in[c_top])
    begin
      mant_d             = mant_in[c_top:4]; // Already denormal
      ext_d              = {mant_in[3:0], {$bits(mant_t){1'b0}}};
      flags_d[c_flag_uf] = 1'b1;
    end
    else if (exp_in >= exp_max_in)
    begin
      exp_d              = exp_max;          // Inf
      flags_d[c_flag_of] = 1'b1;
      flags_d[c_flag_nx] = 1'b1;
      exact_d            = 1'b1;
    end
    else if (mant_in[c_top])
    begin
      mant_d = mant_in[c_top:4];             // 1.xxx
      ext_d  = {mant_in[3:0], {$bits(mant_t){1'b0}}};
      exp_d  = exp_in[7:0];
    end
    else
    begin
      mant_d = mant_in[c_top-1:3];           // 0.1xx, shift left once
      ext_d  = {mant_in[2:0], {($bits(mant_t)+1){1'b0}}};
      exp_d  = exp_dec[7:0];
    end
  end

  //////////////////////////////////////////////////
  // Stage 1 registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
      valid_s1 <= 1'b0;
    else
      valid_s1 <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      mant_norm   <= mant_d;
      mant_ext    <= ext_d;
      exp_norm    <= exp_d;
      sign_s1     <= sign_d;
      flags_s1    <= flags_d;
      fmt_s1      <= fmt;
      rm_s1       <= rm;
      force_exact <= exact_d;
    end
  end

  a_valid_after_rst: assert property (@(posedge clk) rst |=> !valid_s1)
    else $error("valid_s1 high in the cycle after reset");

endmodule

/* design/round_unit.sv */
// Stage 2 of the normalize-and-round pipeline.
// Picks round, guard and sticky bits for the result format, rounds in the
// selected mode, renormalizes on carry, packs and NaN-boxes the result and
// completes the exception flags. Registered on valid_s1, one cycle latency.

`timescale 1ns/100ps

module round_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  valid_s1,
  input  norm_pkg::mant_t       mant_norm,
  input  norm_pkg::mant_ext_t   mant_ext,
  input  norm_pkg::exp_t        exp_norm,
  input  logic                  sign_s1,
  input  norm_pkg::fflags_t     flags_s1,
  input  norm_pkg::fp_fmt_e     fmt_s1,
  input  norm_pkg::round_mode_e rm_s1,
  input  logic                  force_exact,
  output logic                  out_valid,
  output norm_pkg::result_t     result,
  output norm_pkg::fflags_t     fflags
);
  import norm_pkg::*;

  localparam int c_lo16 = c_mant_fp32 - c_mant_fp16;  // Lowest kept bit for FP16

  mant_t   kept;        // Kept mantissa, FP16 zero-padded below
  mant_t   inc;         // One ulp of the format
  logic    rnd_bit;
  logic    grd_bit;
  logic    stk_bit;
  logic    lsb_bit;
  logic    dropped;     // Any discarded bit set
  logic    round_up;
  logic [$bits(mant_t):0] sum;
  logic    carry;
  logic [c_mant_fp32-1:0] frac;
  exp_t    exp_rnd;
  exp_t    exp_max;
  logic    ovf;         // Rounded into the Inf exponent
  logic [c_mant_fp32-1:0] frac_fin;
  result_t result_d;
  fflags_t flags_d;

  //////////////////////////////////////////////////
  // Round bit selection per format
  //////////////////////////////////////////////////
  always_comb
  begin
    if (fmt_s1 == fmt_fp32)
    begin
      kept    = mant_norm;
      inc     = mant_t'(1);
      rnd_bit = mant_ext[$bits(mant_ext_t)-1];
      grd_bit = mant_ext[$bits(mant_ext_t)-2];
      stk_bit = |mant_ext[$bits(mant_ext_t)-3:0];
      lsb_bit = mant_norm[0];
      exp_max = c_exp_max_fp32;
    end
    else
    begin
      kept    = {mant_norm[c_mant_fp32:c_lo16], {c_lo16{1'b0}}};  // Top 11 bits
      inc     = mant_t'(1) << c_lo16;
      rnd_bit = mant_norm[c_lo16-1];
      grd_bit = mant_norm[c_lo16-2];
      stk_bit = (|mant_norm[c_lo16-3:0]) | (|mant_ext);
      lsb_bit = mant_norm[c_lo16];
      exp_max = c_exp_max_fp16;
    end
  end

  assign dropped = rnd_bit | grd_bit | stk_bit;

  always_comb
  begin
    case (rm_s1)
      rm_nearest:   round_up = rnd_bit & (grd_bit | stk_bit | lsb_bit);  // Ties to even
      rm_trunc:     round_up = 1'b0;
      rm_plus_inf:  round_up = dropped & ~sign_s1;
      rm_minus_inf: round_up = dropped & sign_s1;
      default:      round_up = 1'b0;
    endcase
    round_up = round_up & ~force_exact;  // Specials, Inf, flushed zero
  end

  //////////////////////////////////////////////////
  // Add, renormalize, pack
  //////////////////////////////////////////////////
  assign sum   = {1'b0, kept} + (round_up ? {1'b0, inc} : '0);
  assign carry = sum[$bits(mant_t)];
  assign frac  = carry ? sum[c_mant_fp32:1] : sum[c_mant_fp32-1:0];

  always_comb
  begin
    if (carry)
      exp_rnd = exp_norm + 8'd1;
    else if (exp_norm == '0 && sum[c_mant_fp32])
      exp_rnd = 8'd1;                    // Denormal rounded up to normal
    else
      exp_rnd = exp_norm;
  end

  assign ovf      = ~force_exact & (exp_rnd == exp_max);
  assign frac_fin = ovf ? '0 : frac;     // Inf

  assign result_d = (fmt_s1 == fmt_fp32) ?
                    {sign_s1, exp_rnd, frac_fin} :
                    {16'hffff, sign_s1, exp_rnd[c_exp_fp16-1:0], frac_fin[c_mant_fp32-1:c_lo16]};

  always_comb
  begin
    flags_d = flags_s1;
    if (!force_exact && dropped)
      flags_d[c_flag_nx] = 1'b1;
    if (ovf)
    begin
      flags_d[c_flag_of] = 1'b1;
      flags_d[c_flag_nx] = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
      out_valid <= 1'b0;
    else
      out_valid <= valid_s1;
  end

  always_ff @(posedge clk)
  begin
    if (valid_s1)
    begin
      result <= result_d;  // Holds between strobes
      fflags <= flags_d;
    end
  end

  a_out_follows: assert property (@(posedge clk) disable iff (rst)
    1'b1 |=> (out_valid == $past(valid_s1)))
    else $error("out_valid does not follow valid_s1 by one cycle");

endmodule

/* design/norm_round_top.sv */
// Top level of the divide/sqrt normalize-and-round back end.
// in_valid in cycle N gives out_valid, result and fflags in cycle N+2.
// No back-pressure; a new item may enter every cycle.

`timescale 1ns/100ps

module norm_round_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,   // One-cycle strobe
  input  norm_pkg::mant_in_t    mant_in,
  input  norm_pkg::exp_in_t     exp_in,
  input  logic                  sign_in,
  input  logic                  div_en,
  input  logic                  sqrt_en,
  input  logic                  inf_a,
  input  logic                  inf_b,
  input  logic                  zero_a,
  input  logic                  zero_b,
  input  logic                  nan_a,
  input  logic                  nan_b,
  input  logic                  snan,
  input  norm_pkg::fp_fmt_e     fmt,
  input  norm_pkg::round_mode_e rm,
  output logic                  out_valid,
  output norm_pkg::result_t     result,
  output norm_pkg::fflags_t     fflags
);
  import norm_pkg::*;

  // Special-case path
  logic    special_hit;
  logic    special_exp_max;
  logic    special_mant_nan;
  logic    special_sign;
  fflags_t special_flags;

  // Stage 1 to stage 2
  logic        valid_s1;
  mant_t       mant_norm;
  mant_ext_t   mant_ext;
  exp_t        exp_norm;
  logic        sign_s1;
  fflags_t     flags_s1;
  fp_fmt_e     fmt_s1;
  round_mode_e rm_s1;
  logic        force_exact;

  special_case_check u_special_case_check (
    .div_en, .sqrt_en, .sign_in, .inf_a, .inf_b, .zero_a, .zero_b,
    .nan_a, .nan_b, .snan,
    .special_hit, .special_exp_max, .special_mant_nan, .special_sign, .special_flags
  );

  mant_normalizer u_mant_normalizer (
    .clk, .rst, .in_valid, .mant_in, .exp_in, .sign_in, .fmt, .rm,
    .special_hit, .special_exp_max, .special_mant_nan, .special_sign, .special_flags,
    .valid_s1, .mant_norm, .mant_ext, .exp_norm, .sign_s1, .flags_s1,
    .fmt_s1, .rm_s1, .force_exact
  );

  round_unit u_round_unit (
    .clk, .rst, .valid_s1, .mant_norm, .mant_ext, .exp_norm, .sign_s1,
    .flags_s1, .fmt_s1, .rm_s1, .force_exact,
    .out_valid, .result, .fflags
  );

endmodule

/* test/tb_ref_model.svh */
// Reference model for the normalize-and-round testbench.
// Computes the expected packed result and flags of one item from the format
// rules: special-case priority, denormal shift, overflow, four rounding modes
// and FP16 NaN-boxing. Included in the testbench module after the package import.

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Sign, field exponent and fraction into 32 bits, FP16 boxed with ones
function automatic result_t pack_fp(fp_fmt_e f, logic s, int e, logic [63:0] frac);
  result_t r;
  if (f == fmt_fp32)
    r = {s, e[7:0], frac[22:0]};
  else
    r = {16'hffff, s, e[4:0], frac[9:0]};
  return r;
endfunction

// Expected {flags, result}; opf is {nan_a, nan_b, snan, inf_a, inf_b, zero_a, zero_b}
function automatic logic [36:0] expect_item(mant_in_t m, exp_in_t x, logic s, logic div,
                                            logic sqrt, logic [6:0] opf, fp_fmt_e f,
                                            round_mode_e r);
  logic [63:0] full;   // Hidden bit at 51
  logic [63:0] kept;
  logic [63:0] frac;
  logic        rb;
  logic        gb;
  logic        sb;
  logic        up;
  int          kb;     // Kept bits incl hidden
  int          emax;
  int          e;
  fflags_t     fl;
  result_t     nan_r;
  fl    = '0;
  kb    = (f == fmt_fp32) ? 24 : 11;
  emax  = (f == fmt_fp32) ? 255 : 31;
  nan_r = (f == fmt_fp32) ? 32'h7fc0_0000 : 32'hffff_7e00;
  full  = {12'b0, m, 24'b0};
  e     = int'(x);
  if (opf[6] || opf[5])
    return {opf[4], 4'b0000, nan_r};           // NV only for signalling
  if (div && opf[3] && opf[2])
    return {5'b10000, nan_r};                  // Inf/Inf
  if (opf[3])
    return {5'b00000, pack_fp(f, s, emax, 64'd0)};
  if (div && opf[2])
    return {5'b00000, pack_fp(f, s, 0, 64'd0)};  // x/Inf
  if (div && opf[1] && opf[0])
    return {5'b10000, nan_r};                  // 0/0
  if (opf[1])
    return {5'b00000, pack_fp(f, s, 0, 64'd0)};
  if (div && opf[0])
    return {5'b01000, pack_fp(f, s, emax, 64'd0)};  // x/0
  if (sqrt && s)
    return {5'b10000, nan_r};
  if (e == 0 && m == '0)
    return {5'b00000, pack_fp(f, s, 0, 64'd0)};
  // Exponent window
  if (e <= 0)
  begin
    if (1 - e > kb)
      return {5'b00011, pack_fp(f, s, 0, 64'd0)};  // Below the smallest denormal
    fl[c_flag_uf] = 1'b1;
    full = full >> (1 - e);
    e    = 0;
  end
  else if (e == 1 && !m[27])
  begin
    fl[c_flag_uf] = 1'b1;  // Denormal as given
    e             = 0;
  end
  else if (e >= emax)
    return {5'b00101, pack_fp(f, s, emax, 64'd0)};
  else if (!m[27])
  begin
    full = full << 1;
    e    = e - 1;
  end
  // Round at the format's last kept bit
  kept = full >> (52 - kb);
  rb   = full[51 - kb];
  gb   = full[50 - kb];
  sb   = |(full & ((64'd1 << (50 - kb)) - 64'd1));
  case (r)
    rm_nearest:  up = rb && (gb || sb || kept[0]);
    rm_trunc:    up = 1'b0;
    rm_plus_inf: up = (rb || gb || sb) && !s;
    default:     up = (rb || gb || sb) && s;
  endcase
  kept = kept + 64'(up);
  if (kept[kb])
  begin
    frac = kept >> 1;    // Carry, renormalize
    e    = e + 1;
  end
  else
  begin
    frac = kept;
    if (e == 0 && kept[kb - 1])
      e = 1;             // Denormal rounded into normal range
  end
  frac          = frac & ((64'd1 << (kb - 1)) - 64'd1);
  fl[c_flag_nx] = rb || gb || sb;
  if (e >= emax)
  begin
    fl[c_flag_of] = 1'b1;
    fl[c_flag_nx] = 1'b1;
    frac          = '0;
    e             = emax;
  end
  return {fl, pack_fp(f, s, e, frac)};
endfunction

`endif

/* test/tb_norm_round.sv */
// Testbench for the normalize-and-round back end.
// Drives special cases, FP32/FP16 rounding, denormals and overflow into
// norm_round_top. Concurrent assertions compare every output with the
// reference model; each test prints one line, then a closing summary.

`timescale 1ns/100ps

module tb_norm_round;
  import norm_pkg::*;

  `include "tb_ref_model.svh"

  logic        clk = 1'b0;
  logic        rst;
  logic        in_valid;
  mant_in_t    mant_in;
  exp_in_t     exp_in;
  logic        sign_in;
  logic        div_en;
  logic        sqrt_en;
  logic        inf_a;
  logic        inf_b;
  logic        zero_a;
  logic        zero_b;
  logic        nan_a;
  logic        nan_b;
  logic        snan;
  fp_fmt_e     fmt;
  round_mode_e rm;
  logic        out_valid;
  result_t     result;
  fflags_t     fflags;
  logic [1:0]  in_valid_d = 2'b00;  // in_valid one and two cycles back

  result_t exp_res [0:1023];  // Expected results, by issue order
  fflags_t exp_flg [0:1023];
  int      wr_idx = 0;
  int      rd_idx = 0;
  int      err_count = 0;
  bit      timeout_hit = 1'b0;
  string   test_names [1:6] = '{"latency and reset", "special cases", "fp32 rounding",
                                "fp16 results", "denormal and underflow", "overflow"};

  norm_round_top u_norm_round_top (.*);

  always #20 clk = ~clk;      // 40 ns period

  always @(posedge clk)
  begin
    if (!rst && out_valid)
      rd_idx <= rd_idx + 1;   // Consume head
  end

  always @(posedge clk)
    in_valid_d <= {in_valid_d[0], in_valid};

  //////////////////////////////////////////////////
  // Output checks
  //////////////////////////////////////////////////
  a_result: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> result == exp_res[rd_idx[9:0]])
    else
    begin
      $display("Error at %0t ns: result expected %h, got %h", $time,
               exp_res[$sampled(rd_idx[9:0])], $sampled(result));
      err_count++;
    end

  a_flags: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> fflags == exp_flg[rd_idx[9:0]])
    else
    begin
      $display("Error at %0t ns: fflags expected %b, got %b", $time,
               exp_flg[$sampled(rd_idx[9:0])], $sampled(fflags));
      err_count++;
    end

  a_latency: assert property (@(posedge clk) disable iff (rst)
    out_valid == in_valid_d[1])
    else
    begin
      $display("Error at %0t ns: out_valid expected %b, got %b", $time,
               $sampled(in_valid_d[1]), $sampled(out_valid));
      err_count++;
    end

  a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
    else
    begin
      $display("out_valid went high during reset at %0t ns", $time);
      err_count++;
    end

  a_no_stray: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> rd_idx != wr_idx)
    else
    begin
      $display("out_valid at %0t ns with no item outstanding", $time);
      err_count++;
    end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////
  function automatic mant_in_t rand_mant();
    mant_in_t m;
    m = mant_in_t'($urandom);
    if (!m[27])
      m[26] = 1'b1;           // One leading one after the left shift
    return m;
  endfunction

  function automatic exp_in_t rand_exp(int lo, int hi);
    int v;
    v = lo + int'($urandom_range(hi - lo));
    return exp_in_t'(v);
  endfunction

  function automatic round_mode_e rand_rm();
    logic [1:0] v;
    v = 2'($urandom);
    return round_mode_e'(v);
  endfunction

  // One item, 2 ns after the edge, expected value recorded
  task automatic send_item(mant_in_t m, exp_in_t x, logic s, logic [6:0] opf,
                           logic sq, fp_fmt_e f, round_mode_e r);
    logic [36:0] expv;
    @(posedge clk);
    #2;
    {nan_a, nan_b, snan, inf_a, inf_b, zero_a, zero_b} = opf;
    mant_in  = m;
    exp_in   = x;
    sign_in  = s;
    sqrt_en  = sq;
    div_en   = !sq;
    fmt      = f;
    rm       = r;
    in_valid = 1'b1;
    expv = expect_item(m, x, s, !sq, sq, opf, f, r);
    exp_res[wr_idx[9:0]] = expv[31:0];
    exp_flg[wr_idx[9:0]] = expv[36:32];
    wr_idx++;
  endtask

  task automatic idle_input();
    @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (rd_idx != wr_idx && cycles < 20)
    begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (rd_idx != wr_idx)
    begin
      $display("Timeout: %0d items never left the pipeline", wr_idx - rd_idx);
      timeout_hit = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////
  task automatic test_latency();
    send_item(28'h8000000, 10'sd127, 1'b0, 7'b0, 1'b0, fmt_fp32, rm_nearest);
    idle_input();
    for (int i = 0; i < 8; i++)  // Back-to-back burst
      send_item(rand_mant(), rand_exp(1, 254), 1'(i), 7'b0, 1'b0, fmt_fp32,
                round_mode_e'(i[1:0]));
    idle_input();
    wait_drain();
  endtask

  task automatic test_specials();
    logic [6:0] opf_list [0:9];
    logic       sq;
    opf_list = '{7'b1000000, 7'b1010000, 7'b0110000, 7'b0001100, 7'b0001000,
                 7'b0000100, 7'b0000011, 7'b0000010, 7'b0000001, 7'b0000000};
    for (int f = 0; f < 2; f++)
      for (int c = 0; c < 10; c++)
      begin
        sq = (c == 9);              // sqrt of a negative operand
        send_item(rand_mant(), rand_exp(1, 254), sq | 1'($urandom), opf_list[c], sq,
                  fp_fmt_e'(f[0]), rand_rm());
      end
  endtask

  task automatic test_round_fp32();
    for (int r = 0; r < 4; r++)
    begin
      send_item(28'hfffffff, 10'sd100, 1'b0, 7'b0, 1'b0, fmt_fp32, round_mode_e'(r[1:0]));
      send_item(28'h8000018, 10'sd100, 1'b1, 7'b0, 1'b0, fmt_fp32, round_mode_e'(r[1:0]));
      send_item(28'h8000008, 10'sd100, 1'b0, 7'b0, 1'b0, fmt_fp32, round_mode_e'(r[1:0]));
      for (int i = 0; i < 30; i++)
        send_item(rand_mant(), rand_exp(1, 254), 1'($urandom), 7'b0, 1'b0, fmt_fp32,
                  round_mode_e'(r[1:0]));
    end
  endtask

  task automatic test_fp16();
    for (int i = 0; i < 48; i++)
      send_item(rand_mant(), rand_exp(1, 30), 1'($urandom), 7'b0, 1'b0, fmt_fp16, rand_rm());
    send_item(28'hfff0000, 10'sd30, 1'b0, 7'b0, 1'b0, fmt_fp16, rm_nearest);  // Carry to Inf
    send_item(rand_mant(), 10'sd31, 1'b0, 7'b0, 1'b0, fmt_fp16, rand_rm());
    send_item(rand_mant(), 10'sd100, 1'b1, 7'b0, 1'b0, fmt_fp16, rand_rm());
  endtask

  task automatic test_denormal();
    for (int i = 0; i < 12; i++)
    begin
      send_item(rand_mant(), rand_exp(-22, 0), 1'($urandom), 7'b0, 1'b0, fmt_fp32, rand_rm());
      send_item(rand_mant(), rand_exp(-9, 0), 1'($urandom), 7'b0, 1'b0, fmt_fp16, rand_rm());
    end
    send_item(28'h7ffffff, 10'sd1, 1'b0, 7'b0, 1'b0, fmt_fp32, rm_plus_inf);
    send_item(28'hfffffff, -10'sd23, 1'b1, 7'b0, 1'b0, fmt_fp32, rm_trunc);   // Last in range
    send_item(28'hfffffff, -10'sd24, 1'b1, 7'b0, 1'b0, fmt_fp32, rm_nearest);
    send_item(28'hfffffff, -10'sd10, 1'b0, 7'b0, 1'b0, fmt_fp16, rm_nearest);
    send_item(28'hfffffff, -10'sd11, 1'b0, 7'b0, 1'b0, fmt_fp16, rm_nearest);
    send_item(rand_mant(), -10'sd300, 1'b1, 7'b0, 1'b0, fmt_fp32, rand_rm());
  endtask

  task automatic test_overflow();
    send_item(28'hffffff8, 10'sd254, 1'b0, 7'b0, 1'b0, fmt_fp32, rm_nearest);  // Inf
    send_item(28'hffffff8, 10'sd254, 1'b1, 7'b0, 1'b0, fmt_fp32, rm_nearest);
    send_item(28'hffffff8, 10'sd254, 1'b0, 7'b0, 1'b0, fmt_fp32, rm_trunc);    // Max finite
    send_item(28'hffffff8, 10'sd254, 1'b1, 7'b0, 1'b0, fmt_fp32, rm_trunc);
    send_item(28'hffffff8, 10'sd254, 1'b1, 7'b0, 1'b0, fmt_fp32, rm_plus_inf);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial
  begin
    int errs_before;
    int tests_passed;
    int tests_failed;
    tests_passed = 0;
    tests_failed = 0;
    void'($urandom(32'h349a_d75e));
    rst      = 1'b1;
    in_valid = 1'b0;
    mant_in  = '0;
    exp_in   = '0;
    sign_in  = 1'b0;
    div_en   = 1'b0;
    sqrt_en  = 1'b0;
    {nan_a, nan_b, snan, inf_a, inf_b, zero_a, zero_b} = 7'b0;
    fmt      = fmt_fp32;
    rm       = rm_nearest;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int t = 1; t <= 6 && !timeout_hit; t++)
    begin
      errs_before = err_count;
      case (t)
        1: test_latency();
        2: test_specials();
        3: test_round_fp32();
        4: test_fp16();
        5: test_denormal();
        default: test_overflow();
      endcase
      idle_input();
      wait_drain();
      if (err_count == errs_before && !timeout_hit)
      begin
        $display("Test %0d %s: passed", t, test_names[t]);
        tests_passed++;
      end
      else
      begin
        $display("Test %0d %s: failed", t, test_names[t]);
        tests_failed++;
      end
    end
    $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
             err_count);
    if (err_count == 0 && !timeout_hit && tests_failed == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* compile.f */
+incdir+test
design/norm_pkg.sv
design/special_case_check.sv
design/mant_normalizer.sv
design/round_unit.sv
design/norm_round_top.sv
test/tb_norm_round.sv

/* Makefile */
# Verilator build, run, lint and clean for the normalize-and-round back end
TOP := tb_norm_round

all: run

run:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^NO ERRORS$$"

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
